// File: Makefile
# Verilator build for the RV32I core testbench

TOP ?= riscvTopTb
SEED ?= 59498
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(wildcard logic/*.sv tests/*.sv)
BIN := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): build.f $(SOURCES)
	verilator $(VFLAGS) -f build.f --top-module $(TOP) -GseedInit=$(SEED)

run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
logic/rvPkg.sv
logic/decodeIf.sv
logic/instrDecode.sv
logic/aluUnit.sv
logic/memWriteback.sv
logic/fetchUnit.sv
logic/riscvTop.sv
tests/riscvTop_chk.sv
tests/riscvTopTb.sv

// File: logic/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	decodeIf.alu ctl,
	input rvPkg::word_t rs1,
	input rvPkg::word_t rs2,
	input rvPkg::word_t pc,
	output rvPkg::word_t result
);
	import rvPkg::*;

	word_t opA, opB;
	logic [4:0] shamt;

	// operand A is rs1, zero or the executing pc
	assign opA = ctl.src1Pc ? pc : (ctl.src1Zero ? '0 : rs1);
	assign opB = ctl.useImm ? ctl.imm : rs2;
	assign shamt = opB[4:0];

	always_comb begin
		result = opB;  // pass-B
		case (ctl.aluOp)
			aluAdd: result = opA + opB;
			aluSub: result = opA - opB;
			aluSll: result = opA << shamt;
			aluSlt: result = {31'b0, $signed(opA) < $signed(opB)};
			aluSltu: result = {31'b0, opA < opB};
			aluXor: result = opA ^ opB;
			aluSrl: result = opA >> shamt;
			aluSra: result = $signed(opA) >>> shamt;
			aluOr: result = opA | opB;
			aluAnd: result = opA & opB;
			aluEq: result = {31'b0, opA == opB};
			aluNe: result = {31'b0, opA != opB};
			aluGe: result = {31'b0, $signed(opA) >= $signed(opB)};
			aluGeu: result = {31'b0, opA >= opB};
			default: ;
		endcase
	end

endmodule

// File: logic/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf;
	import rvPkg::*;

	aluOp_t aluOp;
	word_t imm;        // already sign-extended
	logic useImm;      // operand B from imm instead of rs2
	logic src1Zero;    // operand A forced to zero (LUI)
	logic src1Pc;      // operand A from pc (AUIPC)
	logic isLoad;
	logic isStore;
	logic isBranch;
	logic isJal;
	logic isJalr;
	funct3_t funct3;
	logic regWrite;    // already cleared for rd == x0

	modport dec (output aluOp, imm, useImm, src1Zero, src1Pc, isLoad, isStore,
		isBranch, isJal, isJalr, funct3, regWrite);
	modport alu (input aluOp, imm, useImm, src1Zero, src1Pc);
	modport mem (input isLoad, isStore, isJal, isJalr, funct3, regWrite);
	modport fetch (input isBranch, isJal, isJalr, imm);

endinterface

// File: logic/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
	parameter int addrWidth = 12,
	parameter rvPkg::word_t resetPc = '0
) (
	input logic CLK,
	input logic RSTn,
	decodeIf.fetch ctl,
	input rvPkg::word_t instr,
	input rvPkg::word_t aluResult,
	output rvPkg::word_t pc,
	output rvPkg::word_t linkAddr,
	output logic [addrWidth-1:0] iMemAddr,
	output logic halt,
	output rvPkg::word_t numInst
);
	import rvPkg::*;

	haltState_t state, nextState;
	word_t nextPc;
	word_t target;  // pc relative, branches and JAL
	logic taken;

	assign linkAddr = pc + 32'd4;
	assign target = pc + ctl.imm;
	assign taken = ctl.isBranch & aluResult[0];
	assign iMemAddr = pc[addrWidth+1:2];  // byte pc to word address

	always_comb begin
		if (halt)
			nextPc = pc;  // frozen
		else if (ctl.isJalr)
			nextPc = {aluResult[31:1], 1'b0};
		else if (ctl.isJal | taken)
			nextPc = target;
		else
			nextPc = linkAddr;
	end

	// watches for haltFirst immediately followed by haltSecond
	always_comb begin
		nextState = state;
		case (state)
			running: if (instr == haltFirst) nextState = armed;
			armed: nextState = (instr == haltSecond) ? halted : running;
			default: ;
		endcase
	end

	// already high in the cycle of the second word
	assign halt = (state == halted) || (state == armed && instr == haltSecond);

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= resetPc;
			state <= running;
			numInst <= '0;
		end else begin
			pc <= nextPc;
			state <= nextState;
			if (state != halted)
				numInst <= numInst + 32'd1;
		end
	end

endmodule

// File: logic/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
	input rvPkg::word_t instr,
	output rvPkg::regAddr_t rfRa1,
	output rvPkg::regAddr_t rfRa2,
	output rvPkg::regAddr_t rfWa,
	decodeIf.dec ctl
);
	import rvPkg::*;

	opcode_t opcode;
	funct3_t f3;
	logic altFn;     // funct7 bit 5, sub and sra
	regAddr_t rd;
	word_t immI, immS, immB, immU, immJ;
	logic useRs1, useRs2, writes;

	// funct3 to operation, common to OP and OP-IMM
	function automatic aluOp_t arithOp(funct3_t f, logic alt);
		case (f)
			3'b000: arithOp = alt ? aluSub : aluAdd;
			3'b001: arithOp = aluSll;
			3'b010: arithOp = aluSlt;
			3'b011: arithOp = aluSltu;
			3'b100: arithOp = aluXor;
			3'b101: arithOp = alt ? aluSra : aluSrl;
			3'b110: arithOp = aluOr;
			default: arithOp = aluAnd;
		endcase
	endfunction

	function automatic aluOp_t branchOp(funct3_t f);
		case (f)
			3'b001: branchOp = aluNe;
			3'b100: branchOp = aluSlt;
			3'b101: branchOp = aluGe;
			3'b110: branchOp = aluSltu;
			3'b111: branchOp = aluGeu;
			default: branchOp = aluEq;  // BEQ
		endcase
	endfunction

	assign opcode = instr[6:0];
	assign f3 = instr[14:12];
	assign altFn = instr[30];
	assign rd = instr[11:7];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		ctl.aluOp = aluPassB;
		ctl.imm = immI;
		ctl.useImm = 1'b0;
		ctl.src1Zero = 1'b0;
		ctl.src1Pc = 1'b0;
		ctl.isLoad = 1'b0;
		ctl.isStore = 1'b0;
		ctl.isBranch = 1'b0;
		ctl.isJal = 1'b0;
		ctl.isJalr = 1'b0;
		useRs1 = 1'b0;
		useRs2 = 1'b0;
		writes = 1'b0;
		case (opcode)
			opOp: begin
				ctl.aluOp = arithOp(f3, altFn);
				{useRs1, useRs2, writes} = 3'b111;
			end
			opOpImm: begin
				// bit 30 is part of the immediate except for shifts
				ctl.aluOp = arithOp(f3, altFn & (f3 == 3'b101));
				ctl.useImm = 1'b1;
				{useRs1, writes} = 2'b11;
			end
			opLoad: begin
				ctl.aluOp = aluAdd;
				ctl.useImm = 1'b1;
				ctl.isLoad = 1'b1;
				{useRs1, writes} = 2'b11;
			end
			opStore: begin
				ctl.aluOp = aluAdd;
				ctl.imm = immS;
				ctl.useImm = 1'b1;
				ctl.isStore = 1'b1;
				{useRs1, useRs2} = 2'b11;
			end
			opBranch: begin
				ctl.aluOp = branchOp(f3);  // compare rs1 against rs2
				ctl.imm = immB;
				ctl.isBranch = 1'b1;
				{useRs1, useRs2} = 2'b11;
			end
			opJal: begin
				ctl.imm = immJ;
				ctl.isJal = 1'b1;
				writes = 1'b1;
			end
			opJalr: begin
				ctl.aluOp = aluAdd;
				ctl.useImm = 1'b1;
				ctl.isJalr = 1'b1;
				{useRs1, writes} = 2'b11;
			end
			opLui: begin
				ctl.aluOp = aluAdd;
				ctl.imm = immU;
				ctl.useImm = 1'b1;
				ctl.src1Zero = 1'b1;
				writes = 1'b1;
			end
			opAuipc: begin
				ctl.aluOp = aluAdd;
				ctl.imm = immU;
				ctl.useImm = 1'b1;
				ctl.src1Pc = 1'b1;
				writes = 1'b1;
			end
			default: ;  // unsupported, no side effects
		endcase
	end

	assign ctl.funct3 = f3;
	assign ctl.regWrite = writes & (rd != '0);

	assign rfRa1 = useRs1 ? instr[19:15] : '0;
	assign rfRa2 = useRs2 ? instr[24:20] : '0;
	assign rfWa = rd;

endmodule

// File: logic/memWriteback.sv
`timescale 1ns/1ps

module memWriteback #(
	parameter int addrWidth = 12
) (
	decodeIf.mem ctl,
	input rvPkg::word_t aluResult,
	input rvPkg::word_t rs2,
	input rvPkg::word_t linkAddr,
	input logic halt,
	input rvPkg::word_t dMemRdata,
	output logic [addrWidth-1:0] dMemAddr,
	output rvPkg::word_t dMemWdata,
	output rvPkg::byteEn_t dMemBe,
	output logic dMemWen,
	output rvPkg::word_t rfWd,
	output logic rfWe
);
	import rvPkg::*;

	logic [1:0] lane;
	logic [4:0] laneShift;  // lane in bits
	word_t laneData, loadData;

	assign lane = aluResult[1:0];
	assign laneShift = {lane, 3'b000};
	assign dMemAddr = aluResult[addrWidth+1:2];  // word address

	// store data moves into the addressed lane
	assign dMemWdata = rs2 << laneShift;

	always_comb begin
		case (ctl.funct3[1:0])
			2'b00: dMemBe = 4'b0001 << lane;
			2'b01: dMemBe = 4'b0011 << {lane[1], 1'b0};
			default: dMemBe = 4'b1111;
		endcase
	end

	// addressed byte or half down to bit 0
	assign laneData = dMemRdata >> laneShift;

	always_comb begin
		case (ctl.funct3)
			3'b000: loadData = {{24{laneData[7]}}, laneData[7:0]};    // LB
			3'b001: loadData = {{16{laneData[15]}}, laneData[15:0]};  // LH
			3'b100: loadData = {24'b0, laneData[7:0]};                // LBU
			3'b101: loadData = {16'b0, laneData[15:0]};               // LHU
			default: loadData = laneData;
		endcase
	end

	assign rfWd = (ctl.isJal | ctl.isJalr) ? linkAddr : (ctl.isLoad ? loadData : aluResult);

	// no writes once the halt sequence is complete
	assign rfWe = ctl.regWrite & ~halt;
	assign dMemWen = ~(ctl.isStore & ~halt);  // active low

endmodule

// File: logic/riscvTop.sv
`timescale 1ns/1ps

module riscvTop #(
	parameter int addrWidth = 12,
	parameter rvPkg::word_t resetPc = '0
) (
	input logic CLK,
	input logic RSTn,           // synchronous, active high

	output logic iMemCsn,
	output logic [addrWidth-1:0] iMemAddr,
	input rvPkg::word_t iMemData,

	output logic dMemCsn,
	input rvPkg::word_t dMemRdata,
	output rvPkg::word_t dMemWdata,
	output logic [addrWidth-1:0] dMemAddr,
	output logic dMemWen,       // active low
	output rvPkg::byteEn_t dMemBe,

	output logic rfWe,
	output rvPkg::regAddr_t rfRa1,
	output rvPkg::regAddr_t rfRa2,
	output rvPkg::regAddr_t rfWa,
	input rvPkg::word_t rfRd1,
	input rvPkg::word_t rfRd2,
	output rvPkg::word_t rfWd,

	output logic halt,
	output rvPkg::word_t numInst,
	output rvPkg::word_t outputPort
);
	import rvPkg::*;

	word_t pc, linkAddr, aluResult;

	decodeIf ctl();

	fetchUnit #(.addrWidth(addrWidth), .resetPc(resetPc)) fetch (
		.CLK(CLK), .RSTn(RSTn), .ctl(ctl.fetch), .instr(iMemData),
		.aluResult(aluResult), .pc(pc), .linkAddr(linkAddr),
		.iMemAddr(iMemAddr), .halt(halt), .numInst(numInst)
	);

	// a deselected instruction memory reads zero, which decodes to no writes
	instrDecode decode (
		.instr(iMemData), .rfRa1(rfRa1), .rfRa2(rfRa2), .rfWa(rfWa), .ctl(ctl.dec)
	);

	aluUnit alu (
		.ctl(ctl.alu), .rs1(rfRd1), .rs2(rfRd2), .pc(pc), .result(aluResult)
	);

	memWriteback #(.addrWidth(addrWidth)) wb (
		.ctl(ctl.mem), .aluResult(aluResult), .rs2(rfRd2), .linkAddr(linkAddr),
		.halt(halt), .dMemRdata(dMemRdata), .dMemAddr(dMemAddr),
		.dMemWdata(dMemWdata), .dMemBe(dMemBe), .dMemWen(dMemWen),
		.rfWd(rfWd), .rfWe(rfWe)
	);

	assign iMemCsn = RSTn;  // deselected during reset
	assign dMemCsn = RSTn;
	assign outputPort = rfWd;

endmodule

// File: logic/rvPkg.sv
package rvPkg;

	typedef logic [31:0] word_t;    // data or instruction word
	typedef logic [4:0] regAddr_t;  // register-file index
	typedef logic [3:0] aluOp_t;
	typedef logic [2:0] funct3_t;   // access size or branch condition
	typedef logic [3:0] byteEn_t;
	typedef logic [6:0] opcode_t;

	// major opcodes
	localparam opcode_t opOp = 7'b0110011;
	localparam opcode_t opOpImm = 7'b0010011;
	localparam opcode_t opLoad = 7'b0000011;
	localparam opcode_t opStore = 7'b0100011;
	localparam opcode_t opBranch = 7'b1100011;
	localparam opcode_t opJal = 7'b1101111;
	localparam opcode_t opJalr = 7'b1100111;
	localparam opcode_t opLui = 7'b0110111;
	localparam opcode_t opAuipc = 7'b0010111;

	// ALU operations, compares leave their flag in bit 0
	localparam aluOp_t aluAdd = 4'd0;
	localparam aluOp_t aluSub = 4'd1;
	localparam aluOp_t aluSll = 4'd2;
	localparam aluOp_t aluSlt = 4'd3;
	localparam aluOp_t aluSltu = 4'd4;
	localparam aluOp_t aluXor = 4'd5;
	localparam aluOp_t aluSrl = 4'd6;
	localparam aluOp_t aluSra = 4'd7;
	localparam aluOp_t aluOr = 4'd8;
	localparam aluOp_t aluAnd = 4'd9;
	localparam aluOp_t aluEq = 4'd10;
	localparam aluOp_t aluNe = 4'd11;
	localparam aluOp_t aluPassB = 4'd12;
	localparam aluOp_t aluGe = 4'd13;   // signed a >= b, for BGE
	localparam aluOp_t aluGeu = 4'd14;  // unsigned a >= b, for BGEU

	// halt sequence
	localparam word_t haltFirst = 32'h00c00093;   // addi x1, x0, 12
	localparam word_t haltSecond = 32'h00008067;  // jalr x0, 0(x1)

	typedef enum logic [1:0] {
		running,
		armed,
		halted
	} haltState_t;

endpackage

// File: tests/riscvTopTb.sv
`timescale 1ns/1ps

module riscvTopTb #(
	parameter int seedInit = 32'he86a
);
	import rvPkg::*;

	localparam int addrWidth = 12;
	localparam word_t resetPc = 32'h0;
	localparam int numRuns = 21;        // arith, load/store, 18 branch cases, jumps
	localparam int cyclesPerRun = 17 + 40;
	localparam int watchdogNs = numRuns * cyclesPerRun * 10 + 1000;

	logic CLK, RSTn;
	logic iMemCsn, dMemCsn, dMemWen, rfWe, halt;
	logic [addrWidth-1:0] iMemAddr, dMemAddr;
	word_t iMemData, dMemRdata, dMemWdata, rfRd1, rfRd2, rfWd, numInst, outputPort;
	byteEn_t dMemBe;
	regAddr_t rfRa1, rfRa2, rfWa;

	word_t imem [0:4095];
	word_t dmem [0:4095];
	word_t rf [0:31];
	word_t rfInit [0:31];  // copied into rf during reset
	word_t progQ[$];
	word_t expQ[$];
	int seed;

	riscvTop #(.addrWidth(addrWidth), .resetPc(resetPc)) UUT (.*);

	always #5 CLK = ~CLK;

	// deselected instruction memory reads zero
	assign iMemData = iMemCsn ? '0 : imem[iMemAddr];
	assign dMemRdata = dmem[dMemAddr];
	assign rfRd1 = (rfRa1 == 5'd0) ? '0 : rf[rfRa1];
	assign rfRd2 = (rfRa2 == 5'd0) ? '0 : rf[rfRa2];

	always @(posedge CLK) begin
		if (RSTn) begin
			for (int k = 0; k < 32; k++)
				rf[k] <= rfInit[k];
			for (int k = 0; k < 4096; k++)
				dmem[k] <= '0;
		end else begin
			if (!dMemWen && !dMemCsn)
				for (int k = 0; k < 4; k++)
					if (dMemBe[k])
						dmem[dMemAddr][8*k +: 8] <= dMemWdata[8*k +: 8];
			if (rfWe && rfWa != 5'd0)
				rf[rfWa] <= rfWd;
		end
	end

	function automatic word_t encR(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1,
		logic [2:0] f3, regAddr_t rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t encI(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3,
		regAddr_t rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t encS(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t encB(logic [12:0] imm, regAddr_t rs2, regAddr_t rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t encJ(logic [20:0] imm, regAddr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// RV32I integer rules with alt selecting sub and sra
	function automatic word_t refArith(logic [2:0] f3, logic alt, word_t x, word_t y);
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'b0, $signed(x) < $signed(y)};
			3'd3: return {31'b0, x < y};
			3'd4: return x ^ y;
			3'd5: return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic branchRule(logic [2:0] f3, word_t x, word_t y);
		case (f3)
			3'd0: return x == y;
			3'd1: return x != y;
			3'd4: return $signed(x) < $signed(y);
			3'd5: return $signed(x) >= $signed(y);
			3'd6: return x < y;
			default: return x >= y;
		endcase
	endfunction

	task automatic reportFailure(string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic checkWord(string name, word_t got, word_t exp);
		if (got !== exp)
			reportFailure($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkReg(regAddr_t r, word_t exp);
		if (rf[r] !== exp)
			reportFailure($sformatf("error: x%0d got %h expected %h", r, rf[r], exp));
	endtask

	task automatic checkBe(byteEn_t got, byteEn_t exp);
		if (got !== exp)
			reportFailure($sformatf("error: dMemBe got %h expected %h", got, exp));
	endtask

	task automatic nextCycle();
		@(posedge CLK);
		@(negedge CLK);
	endtask

	task automatic loadProgram();
		for (int k = 0; k < 4096; k++)
			imem[k] = '0;
		foreach (progQ[k])
			imem[k] = progQ[k];
	endtask

	// reset for 16 cycles, check the reset state, then release
	task automatic resetCore();
		@(negedge CLK);
		RSTn = 1'b1;
		repeat (16) @(negedge CLK);
		checkWord("iMemCsn", 32'(iMemCsn), 1);
		checkWord("dMemCsn", 32'(dMemCsn), 1);
		checkWord("rfWe", 32'(rfWe), 0);
		checkWord("dMemWen", 32'(dMemWen), 1);
		checkWord("halt", 32'(halt), 0);
		checkWord("numInst", numInst, 0);
		RSTn = 1'b0;
		#1;
		checkWord("iMemAddr", 32'(iMemAddr), 32'(resetPc[addrWidth+1:2]));
	endtask

	task automatic waitHalt(int limit);
		int n;
		n = 0;
		while (!halt) begin
			if (n == limit)
				reportFailure("core did not halt within its cycle limit");
			nextCycle();
			n++;
		end
	endtask

	task automatic pushHalt();
		progQ.push_back(32'h00c00093);
		progQ.push_back(32'h00008067);
	endtask

	task automatic testArith();
		word_t a, b, immX;
		regAddr_t rd;
		int n;
		a = $random(seed);
		b = $random(seed);
		a[31] = 1'b1;  // signed and unsigned forms differ
		b[31] = 1'b0;
		b[0] = 1'b1;   // nonzero shift amount
		immX = 32'hfffff8a5;
		rfInit[1] = a;
		rfInit[2] = b;
		progQ.delete();
		expQ.delete();
		for (int f = 0; f < 8; f++) begin
			rd = regAddr_t'(3 + progQ.size());
			progQ.push_back(encR(7'h00, 5'd2, 5'd1, 3'(f), rd));
			expQ.push_back(refArith(3'(f), 1'b0, a, b));
			if (f == 0 || f == 5) begin
				rd = regAddr_t'(3 + progQ.size());
				progQ.push_back(encR(7'h20, 5'd2, 5'd1, 3'(f), rd));
				expQ.push_back(refArith(3'(f), 1'b1, a, b));
			end
		end
		for (int f = 0; f < 8; f++) begin
			rd = regAddr_t'(3 + progQ.size());
			if (f == 1 || f == 5) begin  // shift amount 13
				progQ.push_back(encI(12'h00d, 5'd1, 3'(f), rd, 7'b0010011));
				expQ.push_back(refArith(3'(f), 1'b0, a, 32'd13));
			end else begin
				progQ.push_back(encI(immX[11:0], 5'd1, 3'(f), rd, 7'b0010011));
				expQ.push_back(refArith(3'(f), 1'b0, a, immX));
			end
			if (f == 5) begin
				rd = regAddr_t'(3 + progQ.size());
				progQ.push_back(encI(12'h40d, 5'd1, 3'(f), rd, 7'b0010011));
				expQ.push_back(refArith(3'(f), 1'b1, a, 32'd13));
			end
		end
		rd = regAddr_t'(3 + progQ.size());
		progQ.push_back({20'h12345, rd, 7'b0110111});
		expQ.push_back(32'h12345000);
		rd = regAddr_t'(3 + progQ.size());
		expQ.push_back(resetPc + 32'(4 * progQ.size()) + 32'h00abc000);  // executing pc
		progQ.push_back({20'h00abc, rd, 7'b0010111});
		pushHalt();
		loadProgram();
		resetCore();
		n = expQ.size();
		for (int k = 0; k < n; k++) begin
			checkWord("rfWd", rfWd, expQ[k]);
			checkWord("outputPort", outputPort, expQ[k]);
			checkWord("rfWe", 32'(rfWe), 1);
			nextCycle();
		end
		waitHalt(8);
		nextCycle();
		for (int k = 0; k < n; k++)
			checkReg(regAddr_t'(3 + k), expQ[k]);
	endtask

	task automatic checkStore(byteEn_t be, word_t data, word_t addr);
		word_t mask;
		for (int k = 0; k < 4; k++)
			mask[8*k +: 8] = {8{be[k]}};
		checkBe(dMemBe, be);
		checkWord("dMemWen", 32'(dMemWen), 0);
		checkWord("rfWe", 32'(rfWe), 0);
		checkWord("dMemAddr", 32'(dMemAddr), addr);
		checkWord("dMemWdata", dMemWdata & mask, data & mask);
	endtask

	task automatic testLoadStore();
		word_t d;
		d = $random(seed);
		d[15] = 1'b1;  // both extensions differ
		d[31] = 1'b1;
		d[1:0] = 2'd0;  // low bits tag each lane
		d[9:8] = 2'd1;
		d[17:16] = 2'd2;
		d[25:24] = 2'd3;
		rfInit[5] = 32'h100;
		rfInit[6] = d;
		progQ.delete();
		for (int k = 0; k < 4; k++)
			progQ.push_back(encS(12'(4 + k), 5'd6, 5'd5, 3'd0));
		progQ.push_back(encS(12'd8, 5'd6, 5'd5, 3'd1));
		progQ.push_back(encS(12'd14, 5'd6, 5'd5, 3'd1));
		progQ.push_back(encS(12'd16, 5'd6, 5'd5, 3'd2));
		progQ.push_back(encI(12'd17, 5'd5, 3'd0, 5'd7, 7'b0000011));
		progQ.push_back(encI(12'd19, 5'd5, 3'd4, 5'd8, 7'b0000011));
		progQ.push_back(encI(12'd8, 5'd5, 3'd1, 5'd9, 7'b0000011));
		progQ.push_back(encI(12'd14, 5'd5, 3'd5, 5'd10, 7'b0000011));
		progQ.push_back(encI(12'd16, 5'd5, 3'd2, 5'd11, 7'b0000011));
		pushHalt();
		loadProgram();
		resetCore();
		for (int k = 0; k < 4; k++) begin
			checkStore(byteEn_t'(4'b0001 << k), d << (8 * k), 32'h41);
			nextCycle();
		end
		checkStore(4'b0011, d, 32'h42);
		nextCycle();
		checkStore(4'b1100, d << 16, 32'h43);
		nextCycle();
		checkStore(4'b1111, d, 32'h44);
		nextCycle();
		checkWord("rfWd", rfWd, {{24{d[15]}}, d[15:8]});  // lb
		nextCycle();
		checkWord("rfWd", rfWd, {24'b0, d[31:24]});
		nextCycle();
		checkWord("rfWd", rfWd, {{16{d[15]}}, d[15:0]});
		nextCycle();
		checkWord("rfWd", rfWd, {16'b0, d[15:0]});
		nextCycle();
		checkWord("rfWd", rfWd, d);
		waitHalt(8);
		nextCycle();
		checkReg(5'd11, d);
	endtask

	task automatic testBranch();
		word_t xa[3], xb[3];
		logic [2:0] conds[6];
		logic taken;
		xa = '{32'hfffffffb, 32'd7, 32'd3};
		xb = '{32'd3, 32'd7, 32'hfffffffb};
		conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		for (int p = 0; p < 3; p++) begin
			for (int c = 0; c < 6; c++) begin
				rfInit[1] = xa[p];
				rfInit[2] = xb[p];
				progQ.delete();
				progQ.push_back(encB(13'd16, 5'd2, 5'd1, conds[c]));
				loadProgram();
				resetCore();
				taken = branchRule(conds[c], xa[p], xb[p]);
				nextCycle();
				checkWord("iMemAddr", 32'(iMemAddr), taken ? 32'd4 : 32'd1);
			end
		end
	endtask

	task automatic testJumpHalt();
		rfInit[3] = 32'h20;
		progQ.delete();
		progQ.push_back(encJ(21'd12, 5'd1));
		progQ.push_back(32'h0);
		progQ.push_back(32'h0);
		progQ.push_back(encI(12'd5, 5'd3, 3'd0, 5'd2, 7'b1100111));  // 0x25 with bit 0 cleared
		for (int k = 4; k < 9; k++)
			progQ.push_back(32'h0);
		progQ.push_back(32'h00c00093);  // first word alone
		progQ.push_back({20'h0, 5'd4, 7'b0010111});  // auipc x4, 0 shows the jalr target
		pushHalt();
		loadProgram();
		resetCore();
		checkWord("rfWd", rfWd, 32'd4);
		nextCycle();
		checkWord("iMemAddr", 32'(iMemAddr), 3);
		checkWord("rfWd", rfWd, 32'd16);
		checkWord("rfRa1", 32'(rfRa1), 3);
		checkWord("rfRa2", 32'(rfRa2), 0);  // unused operand
		checkWord("rfWa", 32'(rfWa), 2);
		nextCycle();
		checkWord("iMemAddr", 32'(iMemAddr), 9);
		nextCycle();
		checkWord("halt", 32'(halt), 0);
		checkWord("rfWd", rfWd, 32'd40);
		nextCycle();
		checkWord("halt", 32'(halt), 0);
		nextCycle();
		checkWord("halt", 32'(halt), 1);  // second word's cycle
		checkWord("rfWe", 32'(rfWe), 0);
		for (int k = 0; k < 4; k++) begin
			nextCycle();
			checkWord("numInst", numInst, 32'd6);
			checkWord("iMemAddr", 32'(iMemAddr), 12);
		end
		checkReg(5'd1, 32'd12);
		checkReg(5'd2, 32'd16);
	endtask

	initial begin
		#(watchdogNs);
		reportFailure("watchdog expired before the tests finished");
	end

	initial begin
		CLK = 1'b0;
		RSTn = 1'b1;
		seed = seedInit;
		for (int k = 0; k < 32; k++)
			rfInit[k] = '0;
		progQ.delete();
		loadProgram();
		testArith();
		testLoadStore();
		testBranch();
		testJumpHalt();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: tests/riscvTop_chk.sv
`timescale 1ns/1ps

module riscvTopChk #(
	parameter int addrWidth = 12
) (
	input logic CLK,
	input logic RSTn,
	input logic rfWe,
	input logic dMemWen,
	input logic halt,
	input logic [addrWidth-1:0] iMemAddr,
	input rvPkg::byteEn_t dMemBe
);

	// no writes in reset or once halted
	strobesIdle: assert property (@(posedge CLK) (RSTn || halt) |-> (!rfWe && dMemWen))
		else $error("write strobe active during reset or halt");

	pcFrozen: assert property (@(posedge CLK) disable iff (RSTn)
		halt |=> $stable(iMemAddr))
		else $error("iMemAddr moved while halted");

	storeHasLanes: assert property (@(posedge CLK) !dMemWen |-> dMemBe != 4'b0000)
		else $error("store without byte enables");

endmodule

bind riscvTop riscvTopChk #(.addrWidth(addrWidth)) chk (.*);
